/* logic/axi_sram_cfg.svh */
`ifndef AXI_SRAM_CFG_SVH
`define AXI_SRAM_CFG_SVH

// axi port widths
`define AXI_ID_BITS   4
`define AXI_ADDR_BITS 32
`define AXI_DATA_BITS 32
`define AXI_STRB_BITS 4

// beats = len + 1
`define AXI_LEN_BITS  4

// word address, taken from byte address bit 2 upward
`define SRAM_A_BITS   14

`endif

/* logic/axi_pkg.sv */
`default_nettype none

package axi_pkg;

    // burst encoding as on the AXI bus
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } burst_t;

    // response encoding, only OKAY is driven by this slave
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_t;

endpackage

`default_nettype wire

/* logic/sram_pkg.sv */
`default_nettype none

package sram_pkg;

    // per-cycle sram command, also used as the read tag
    typedef enum logic [1:0] {
        NONE  = 2'b00,
        READ  = 2'b01,
        WRITE = 2'b10
    } sram_op_t;

endpackage

`default_nettype wire

/* logic/axi_slave_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none
`include "axi_sram_cfg.svh"

module axi_slave_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    // aw
    input  logic                       awvalid_i,
    output logic                       awready_o,
    input  logic [`AXI_ADDR_BITS-1:0]  awaddr_i,
    input  logic [`AXI_ID_BITS-1:0]    awid_i,
    input  logic [`AXI_LEN_BITS-1:0]   awlen_i,
    input  axi_pkg::burst_t            awburst_i,
    // w
    input  logic                       wvalid_i,
    output logic                       wready_o,
    input  logic [`AXI_DATA_BITS-1:0]  wdata_i,
    input  logic [`AXI_STRB_BITS-1:0]  wstrb_i,
    input  logic                       wlast_i,
    // b
    output logic                       bvalid_o,
    input  logic                       bready_i,
    output logic [`AXI_ID_BITS-1:0]    bid_o,
    output axi_pkg::resp_t             bresp_o,
    // ar
    input  logic                       arvalid_i,
    output logic                       arready_o,
    input  logic [`AXI_ADDR_BITS-1:0]  araddr_i,
    input  logic [`AXI_ID_BITS-1:0]    arid_i,
    input  logic [`AXI_LEN_BITS-1:0]   arlen_i,
    input  axi_pkg::burst_t            arburst_i,
    // sram command
    output sram_pkg::sram_op_t         cmd_op_o,
    output logic [`SRAM_A_BITS-1:0]    cmd_addr_o,
    output logic [`AXI_DATA_BITS-1:0]  cmd_wdata_o,
    output logic [`AXI_STRB_BITS-1:0]  cmd_wbe_n_o,
    // read tag and return credit
    output logic                       tag_valid_o,
    output logic [`AXI_ID_BITS-1:0]    tag_id_o,
    output logic                       tag_last_o,
    input  logic [1:0]                 credit_i
);
    import axi_pkg::*;
    import sram_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WRITE,
        S_RESP,
        S_READ
    } state_t;

    state_t                     state;
    logic                       aw_hs;
    logic                       ar_hs;
    logic                       w_hs;
    logic                       rd_issue;

    logic [`AXI_ID_BITS-1:0]    id_q;
    burst_t                     burst_q;
    logic [`SRAM_A_BITS-1:0]    addr_q;
    logic [`SRAM_A_BITS-1:0]    addr_next;
    logic [`AXI_LEN_BITS-1:0]   cnt_q;

    sram_op_t                   cmd_op_q;
    logic [`SRAM_A_BITS-1:0]    cmd_addr_q;
    logic [`AXI_DATA_BITS-1:0]  cmd_wdata_q;
    logic [`AXI_STRB_BITS-1:0]  cmd_wbe_n_q;
    logic                       tag_valid_q;
    logic [`AXI_ID_BITS-1:0]    tag_id_q;
    logic                       tag_last_q;
    logic                       bvalid_q;

    // write address wins when both arrive together
    assign awready_o = (state == S_IDLE);
    assign arready_o = (state == S_IDLE) && !awvalid_i;
    assign wready_o  = (state == S_WRITE);

    assign aw_hs    = awvalid_i && awready_o;
    assign ar_hs    = arvalid_i && arready_o;
    assign w_hs     = wvalid_i && wready_o;
    assign rd_issue = (state == S_READ) && (credit_i != 2'd0);

    // wrap bursts step like incr
    assign addr_next = (burst_q == FIXED) ? addr_q : addr_q + 1'b1;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state       <= S_IDLE;
            cmd_op_q    <= NONE;
            tag_valid_q <= 1'b0;
            bvalid_q    <= 1'b0;
        end else begin
            cmd_op_q    <= w_hs ? WRITE : (rd_issue ? READ : NONE);
            tag_valid_q <= rd_issue;
            case (state)
                S_IDLE: begin
                    if (aw_hs) begin
                        state <= S_WRITE;
                    end else if (ar_hs) begin
                        state <= S_READ;
                    end
                end
                S_WRITE: begin
                    if (w_hs && wlast_i) begin
                        state <= S_RESP;
                    end
                end
                S_RESP: begin
                    // one cycle after the last write command
                    if (!bvalid_q) begin
                        bvalid_q <= 1'b1;
                    end else if (bready_i) begin
                        bvalid_q <= 1'b0;
                        state    <= S_IDLE;
                    end
                end
                S_READ: begin
                    if (rd_issue && (cnt_q == '0)) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            id_q    <= awid_i;
            burst_q <= awburst_i;
            addr_q  <= awaddr_i[`SRAM_A_BITS+1:2];
            cnt_q   <= awlen_i;
        end else if (ar_hs) begin
            id_q    <= arid_i;
            burst_q <= arburst_i;
            addr_q  <= araddr_i[`SRAM_A_BITS+1:2];
            cnt_q   <= arlen_i;
        end else if (w_hs || rd_issue) begin
            addr_q  <= addr_next;
            cnt_q   <= cnt_q - 1'b1;
        end
        cmd_addr_q  <= addr_q;
        cmd_wdata_q <= wdata_i;
        // reads keep every byte write disabled
        cmd_wbe_n_q <= w_hs ? ~wstrb_i : '1;
        tag_id_q    <= id_q;
        tag_last_q  <= (cnt_q == '0);
    end

    assign cmd_op_o    = cmd_op_q;
    assign cmd_addr_o  = cmd_addr_q;
    assign cmd_wdata_o = cmd_wdata_q;
    assign cmd_wbe_n_o = cmd_wbe_n_q;
    assign tag_valid_o = tag_valid_q;
    assign tag_id_o    = tag_id_q;
    assign tag_last_o  = tag_last_q;

    assign bvalid_o = bvalid_q;
    assign bid_o    = id_q;
    assign bresp_o  = OKAY;

    // w beats only inside a write burst and the last one matches awlen
    a_w_in_write: assert property (@(posedge clk) disable iff (!rst)
        w_hs |-> (state == S_WRITE) && (wlast_i == (cnt_q == '0)));

    a_b_hold: assert property (@(posedge clk) disable iff (!rst)
        bvalid_o && !bready_i |=> bvalid_o && $stable(bid_o));

    // read issued only with buffer room seen the cycle before
    a_rd_credit: assert property (@(posedge clk) disable iff (!rst)
        (cmd_op_o == READ) |-> ($past(credit_i) != 2'd0));

endmodule

`default_nettype wire

/* logic/sram_macro.sv */
`timescale 1ns/10ps
`default_nettype none
`include "axi_sram_cfg.svh"

module sram_macro (
    input  logic                       clk,
    input  logic                       cs_i,
    input  logic                       oe_i,
    input  logic [`SRAM_A_BITS-1:0]    a_i,
    input  logic [`AXI_DATA_BITS-1:0]  di_i,
    input  logic [`AXI_STRB_BITS-1:0]  web_i,
    output logic [`AXI_DATA_BITS-1:0]  do_o
);
    localparam int WORDS = 1 << `SRAM_A_BITS;

    logic [`AXI_DATA_BITS-1:0] mem [0:WORDS-1];
    logic [`AXI_DATA_BITS-1:0] do_q;

    // byte lanes written independently, active low enables
    always_ff @(posedge clk) begin
        for (int i = 0; i < `AXI_STRB_BITS; i++) begin
            if (cs_i && !web_i[i]) begin
                mem[a_i][8*i +: 8] <= di_i[8*i +: 8];
            end
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        if (cs_i && oe_i) begin
            do_q <= mem[a_i];
        end
    end

    assign do_o = do_q;

    a_rd_no_write: assert property (@(posedge clk)
        cs_i && oe_i |-> (web_i == '1));

endmodule

`default_nettype wire

/* logic/sram_read_return.sv */
`timescale 1ns/10ps
`default_nettype none
`include "axi_sram_cfg.svh"

module sram_read_return (
    input  logic                       clk,
    input  logic                       rst,
    // tag from the control stage
    input  logic                       tag_valid_i,
    input  logic [`AXI_ID_BITS-1:0]    tag_id_i,
    input  logic                       tag_last_i,
    // sram output
    input  logic [`AXI_DATA_BITS-1:0]  rdata_i,
    // r
    output logic                       rvalid_o,
    input  logic                       rready_i,
    output logic [`AXI_DATA_BITS-1:0]  rdata_o,
    output logic [`AXI_ID_BITS-1:0]    rid_o,
    output logic                       rlast_o,
    output axi_pkg::resp_t             rresp_o,
    output logic [1:0]                 credit_o
);
    import axi_pkg::*;
    import sram_pkg::*;

    localparam logic [1:0] DEPTH = 2'd2;

    sram_op_t                   tag_op_q;
    logic [`AXI_ID_BITS-1:0]    tag_id_q;
    logic                       tag_last_q;

    logic [`AXI_DATA_BITS-1:0]  data_q [0:1];
    logic [`AXI_ID_BITS-1:0]    rid_q  [0:1];
    logic                       last_q [0:1];
    logic                       wr_ptr;
    logic                       rd_ptr;
    logic [1:0]                 count_q;
    logic                       push;
    logic                       pop;

    // tag lines up with the registered sram word
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            tag_op_q <= NONE;
        end else begin
            tag_op_q <= tag_valid_i ? READ : NONE;
        end
    end

    always_ff @(posedge clk) begin
        tag_id_q   <= tag_id_i;
        tag_last_q <= tag_last_i;
    end

    assign push = (tag_op_q == READ);
    assign pop  = rvalid_o && rready_i;

    always_ff @(posedge clk) begin
        if (push) begin
            data_q[wr_ptr] <= rdata_i;
            rid_q[wr_ptr]  <= tag_id_q;
            last_q[wr_ptr] <= tag_last_q;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wr_ptr  <= 1'b0;
            rd_ptr  <= 1'b0;
            count_q <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count_q <= count_q + {1'b0, push} - {1'b0, pop};
        end
    end

    assign rvalid_o = (count_q != 2'd0);
    assign rdata_o  = data_q[rd_ptr];
    assign rid_o    = rid_q[rd_ptr];
    assign rlast_o  = last_q[rd_ptr];
    assign rresp_o  = OKAY;

    // free slots less both reads still on their way
    assign credit_o = DEPTH - count_q - {1'b0, tag_valid_i} - {1'b0, push};

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst)
        push |-> (count_q != DEPTH));

    a_r_stable: assert property (@(posedge clk) disable iff (!rst)
        rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rid_o)
            && $stable(rlast_o));

endmodule

`default_nettype wire

/* logic/axi_sram_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "axi_sram_cfg.svh"

module axi_sram_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       awvalid_i,
    output logic                       awready_o,
    input  logic [`AXI_ADDR_BITS-1:0]  awaddr_i,
    input  logic [`AXI_ID_BITS-1:0]    awid_i,
    input  logic [`AXI_LEN_BITS-1:0]   awlen_i,
    input  axi_pkg::burst_t            awburst_i,
    input  logic                       wvalid_i,
    output logic                       wready_o,
    input  logic [`AXI_DATA_BITS-1:0]  wdata_i,
    input  logic [`AXI_STRB_BITS-1:0]  wstrb_i,
    input  logic                       wlast_i,
    output logic                       bvalid_o,
    input  logic                       bready_i,
    output logic [`AXI_ID_BITS-1:0]    bid_o,
    output axi_pkg::resp_t             bresp_o,
    input  logic                       arvalid_i,
    output logic                       arready_o,
    input  logic [`AXI_ADDR_BITS-1:0]  araddr_i,
    input  logic [`AXI_ID_BITS-1:0]    arid_i,
    input  logic [`AXI_LEN_BITS-1:0]   arlen_i,
    input  axi_pkg::burst_t            arburst_i,
    output logic                       rvalid_o,
    input  logic                       rready_i,
    output logic [`AXI_DATA_BITS-1:0]  rdata_o,
    output logic [`AXI_ID_BITS-1:0]    rid_o,
    output logic                       rlast_o,
    output axi_pkg::resp_t             rresp_o
);
    import sram_pkg::*;

    sram_op_t                   cmd_op;
    logic [`SRAM_A_BITS-1:0]    cmd_addr;
    logic [`AXI_DATA_BITS-1:0]  cmd_wdata;
    logic [`AXI_STRB_BITS-1:0]  cmd_wbe_n;
    logic                       tag_valid;
    logic [`AXI_ID_BITS-1:0]    tag_id;
    logic                       tag_last;
    logic [1:0]                 credit;
    logic [`AXI_DATA_BITS-1:0]  sram_rdata;
    logic                       sram_cs;
    logic                       sram_oe;

    assign sram_cs = (cmd_op != NONE);
    assign sram_oe = (cmd_op == READ);

    axi_slave_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .awvalid_i   (awvalid_i),
        .awready_o   (awready_o),
        .awaddr_i    (awaddr_i),
        .awid_i      (awid_i),
        .awlen_i     (awlen_i),
        .awburst_i   (awburst_i),
        .wvalid_i    (wvalid_i),
        .wready_o    (wready_o),
        .wdata_i     (wdata_i),
        .wstrb_i     (wstrb_i),
        .wlast_i     (wlast_i),
        .bvalid_o    (bvalid_o),
        .bready_i    (bready_i),
        .bid_o       (bid_o),
        .bresp_o     (bresp_o),
        .arvalid_i   (arvalid_i),
        .arready_o   (arready_o),
        .araddr_i    (araddr_i),
        .arid_i      (arid_i),
        .arlen_i     (arlen_i),
        .arburst_i   (arburst_i),
        .cmd_op_o    (cmd_op),
        .cmd_addr_o  (cmd_addr),
        .cmd_wdata_o (cmd_wdata),
        .cmd_wbe_n_o (cmd_wbe_n),
        .tag_valid_o (tag_valid),
        .tag_id_o    (tag_id),
        .tag_last_o  (tag_last),
        .credit_i    (credit)
    );

    sram_macro u_sram (
        .clk   (clk),
        .cs_i  (sram_cs),
        .oe_i  (sram_oe),
        .a_i   (cmd_addr),
        .di_i  (cmd_wdata),
        .web_i (cmd_wbe_n),
        .do_o  (sram_rdata)
    );

    sram_read_return u_ret (
        .clk         (clk),
        .rst         (rst),
        .tag_valid_i (tag_valid),
        .tag_id_i    (tag_id),
        .tag_last_i  (tag_last),
        .rdata_i     (sram_rdata),
        .rvalid_o    (rvalid_o),
        .rready_i    (rready_i),
        .rdata_o     (rdata_o),
        .rid_o       (rid_o),
        .rlast_o     (rlast_o),
        .rresp_o     (rresp_o),
        .credit_o    (credit)
    );

endmodule

`default_nettype wire

/* tests/axi_master_tasks.svh */
`ifndef AXI_MASTER_TASKS_SVH
`define AXI_MASTER_TASKS_SVH

// xorshift32 step on the shared generator state
function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
endfunction

// every task starts and ends on a falling edge
task automatic send_aw(input logic [`AXI_ID_BITS-1:0] id, input logic [31:0] addr,
                       input logic [`AXI_LEN_BITS-1:0] len, input burst_t burst);
    awvalid_i = 1'b1;
    awid_i    = id;
    awaddr_i  = addr;
    awlen_i   = len;
    awburst_i = burst;
    #4;
    while (!awready_o) begin
        @(negedge clk);
        #4;
    end
    // a waiting read must lose against the write
    if (arvalid_i) begin
        check("arready", 32'd0, 32'(arready_o));
    end
    @(negedge clk);
    awvalid_i = 1'b0;
endtask

task automatic send_ar(input logic [`AXI_ID_BITS-1:0] id, input logic [31:0] addr,
                       input logic [`AXI_LEN_BITS-1:0] len, input burst_t burst);
    arvalid_i = 1'b1;
    arid_i    = id;
    araddr_i  = addr;
    arlen_i   = len;
    arburst_i = burst;
    #4;
    while (!arready_o) begin
        @(negedge clk);
        #4;
    end
    @(negedge clk);
    arvalid_i = 1'b0;
endtask

task automatic send_w(input logic [`AXI_DATA_BITS-1:0] data,
                      input logic [`AXI_STRB_BITS-1:0] strb, input logic last);
    wvalid_i = 1'b1;
    wdata_i  = data;
    wstrb_i  = strb;
    wlast_i  = last;
    #4;
    while (!wready_o) begin
        @(negedge clk);
        #4;
    end
    @(negedge clk);
    wvalid_i = 1'b0;
endtask

task automatic wait_b(input logic [`AXI_ID_BITS-1:0] id, input int hold);
    #4;
    while (!bvalid_o) begin
        @(negedge clk);
        #4;
    end
    // bready low, response held and new addresses blocked
    for (int i = 0; i < hold; i++) begin
        @(negedge clk);
        #4;
        check("bvalid", 32'd1, 32'(bvalid_o));
        check("awready", 32'd0, 32'(awready_o));
    end
    @(negedge clk);
    bready_i = 1'b1;
    #4;
    check("bvalid", 32'd1, 32'(bvalid_o));
    check("bid", 32'(id), 32'(bid_o));
    check("bresp", 32'(OKAY), 32'(bresp_o));
    @(negedge clk);
    bready_i = 1'b0;
endtask

// pops expected words from exp_q in order
task automatic collect_r(input logic [`AXI_ID_BITS-1:0] id, input int beats);
    int n;
    n = 0;
    while (n < beats) begin
        rready_i = (next_rand() & 32'h3) != 32'h0;
        #4;
        if (rvalid_o && rready_i) begin
            check("rdata", exp_q.pop_front(), rdata_o);
            check("rid", 32'(id), 32'(rid_o));
            check("rlast", 32'(n == beats - 1), 32'(rlast_o));
            check("rresp", 32'(OKAY), 32'(rresp_o));
            n++;
        end
        @(negedge clk);
    end
    // nothing left over once the last beat is out
    rready_i = 1'b0;
    #4;
    check("rvalid", 32'd0, 32'(rvalid_o));
    @(negedge clk);
endtask

`endif

/* tests/axi_sram_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "axi_sram_cfg.svh"

module axi_sram_tb;
    import axi_pkg::*;

    localparam int WINDOW   = 64;
    localparam int NUM_RAND = 40;
    // fill bursts, directed bursts, random write and read pairs
    localparam int NUM_TXN  = 4 + 6 + 2 * NUM_RAND;
    localparam int WDOG_NS  = (NUM_TXN * (16 + 10) + 5) * 10;

    logic                      clk;
    logic                      rst;
    logic                      awvalid_i;
    logic                      awready_o;
    logic [`AXI_ADDR_BITS-1:0] awaddr_i;
    logic [`AXI_ID_BITS-1:0]   awid_i;
    logic [`AXI_LEN_BITS-1:0]  awlen_i;
    burst_t                    awburst_i;
    logic                      wvalid_i;
    logic                      wready_o;
    logic [`AXI_DATA_BITS-1:0] wdata_i;
    logic [`AXI_STRB_BITS-1:0] wstrb_i;
    logic                      wlast_i;
    logic                      bvalid_o;
    logic                      bready_i;
    logic [`AXI_ID_BITS-1:0]   bid_o;
    resp_t                     bresp_o;
    logic                      arvalid_i;
    logic                      arready_o;
    logic [`AXI_ADDR_BITS-1:0] araddr_i;
    logic [`AXI_ID_BITS-1:0]   arid_i;
    logic [`AXI_LEN_BITS-1:0]  arlen_i;
    burst_t                    arburst_i;
    logic                      rvalid_o;
    logic                      rready_i;
    logic [`AXI_DATA_BITS-1:0] rdata_o;
    logic [`AXI_ID_BITS-1:0]   rid_o;
    logic                      rlast_o;
    resp_t                     rresp_o;

    logic [31:0] rng;
    logic [31:0] model [0:WINDOW-1];
    logic [31:0] exp_q [$];

    axi_sram_top uut (.*);

    always #5 clk = ~clk;

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail %s exp %h got %h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    `include "axi_master_tasks.svh"

    // model follows each beat with the strobe merge
    task automatic write_burst(input logic [3:0] id, input int word, input int len,
                               input burst_t burst, input logic full);
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] mask;
        logic [5:0]  widx;
        send_aw(id, 32'(word) << 2, 4'(len), burst);
        for (int i = 0; i <= len; i++) begin
            data = next_rand();
            strb = full ? 4'hf : 4'(next_rand());
            widx = (burst == FIXED) ? 6'(word) : 6'(word + i);
            mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
            model[widx] = (model[widx] & ~mask) | (data & mask);
            send_w(data, strb, i == len);
        end
        wait_b(id, int'(next_rand() % 32'd4));
    endtask

    task automatic read_burst(input logic [3:0] id, input int word, input int len,
                              input burst_t burst);
        logic [5:0] widx;
        for (int i = 0; i <= len; i++) begin
            widx = (burst == FIXED) ? 6'(word) : 6'(word + i);
            exp_q.push_back(model[widx]);
        end
        send_ar(id, 32'(word) << 2, 4'(len), burst);
        collect_r(id, len + 1);
    endtask

    initial begin
        #(WDOG_NS);
        $display("watchdog expired before the test sequence finished");
        $display("CHECKS FAILED");
        $fatal(1, "timeout after %0d ns", WDOG_NS);
    end

    initial begin
        int     len;
        int     word;
        burst_t burst;
        clk       = 1'b0;
        rst       = 1'b0;
        rng       = 32'h619d;
        awvalid_i = 1'b0;
        awaddr_i  = '0;
        awid_i    = '0;
        awlen_i   = '0;
        awburst_i = INCR;
        wvalid_i  = 1'b0;
        wdata_i   = '0;
        wstrb_i   = '0;
        wlast_i   = 1'b0;
        bready_i  = 1'b0;
        arvalid_i = 1'b0;
        araddr_i  = '0;
        arid_i    = '0;
        arlen_i   = '0;
        arburst_i = INCR;
        rready_i  = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check("bvalid", 32'd0, 32'(bvalid_o));
        check("rvalid", 32'd0, 32'(rvalid_o));
        check("wready", 32'd0, 32'(wready_o));
        rst = 1'b1;

        // whole window written first so reads always hit known data
        for (int w = 0; w < WINDOW; w += 16) begin
            write_burst(4'(next_rand()), w, 15, INCR, 1'b1);
        end

        write_burst(4'h3, 5, 0, INCR, 1'b1);
        read_burst(4'h3, 5, 0, INCR);
        write_burst(4'h7, 9, 7, FIXED, 1'b0);
        read_burst(4'h9, 9, 3, FIXED);

        // aw and ar raised on the same edge
        arvalid_i = 1'b1;
        arid_i    = 4'hc;
        araddr_i  = 32'd40 << 2;
        arlen_i   = 4'd3;
        arburst_i = INCR;
        write_burst(4'ha, 40, 3, INCR, 1'b0);
        read_burst(4'hc, 40, 3, INCR);

        for (int t = 0; t < NUM_RAND; t++) begin
            len   = int'(next_rand() % 32'd16);
            burst = burst_t'(2'(next_rand() % 32'd3));
            word  = int'(next_rand() % 32'(WINDOW - ((burst == FIXED) ? 0 : len)));
            write_burst(4'(next_rand()), word, len, burst, (next_rand() & 32'h1) == 32'h0);
            len   = int'(next_rand() % 32'd16);
            burst = burst_t'(2'(next_rand() % 32'd3));
            word  = int'(next_rand() % 32'(WINDOW - ((burst == FIXED) ? 0 : len)));
            read_burst(4'(next_rand()), word, len, burst);
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+logic
+incdir+tests
logic/axi_pkg.sv
logic/sram_pkg.sv
logic/axi_slave_ctrl.sv
logic/sram_macro.sv
logic/sram_read_return.sv
logic/axi_sram_top.sv
tests/axi_sram_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := axi_sram_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard logic/*.svh tests/*.svh)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
